// ==== src/hw_manager_macros.svh ====
`ifndef HW_MANAGER_MACROS_SVH
`define HW_MANAGER_MACROS_SVH

// Board and field widths
`define HWM_NUM_BOARDS 8    // Shim boards in the chassis
`define HWM_BOARD_W    3    // Board index width
`define HWM_STATE_W    4    // Sequencer state width
`define HWM_CODE_W     25   // Status code width
`define HWM_TIMER_W    32   // Shared delay timer

// Settle time before spi_off can be trusted
`define HWM_SPI_INIT_MIN 10

// Default delays in cycles, 250 MHz clock
`define HWM_SHUTDOWN_FORCE_DELAY 25000000   // 100 ms after force release
`define HWM_SHUTDOWN_RESET_PULSE 25000      // 100 us reset pulse
`define HWM_SHUTDOWN_RESET_DELAY 25000000   // 100 ms after reset pulse
`define HWM_SPI_INIT_WAIT        25000000   // 100 ms for SPI init check
`define HWM_SPI_START_WAIT       250000000  // 1 s for SPI start

`endif

// ==== src/hw_manager_pkg.sv ====
`default_nettype none

`include "hw_manager_macros.svh"

package hw_manager_pkg;

  // Sequencer states, IDLE starts at 1 so a zero word reads as invalid
  typedef enum logic [`HWM_STATE_W-1:0] {
    IDLE              = 4'd1,
    CONFIRM_SPI_INIT  = 4'd2,
    RELEASE_SD_F      = 4'd3,
    PULSE_SD_RST      = 4'd4,
    SD_RST_DELAY      = 4'd5,
    CONFIRM_SPI_START = 4'd6,
    RUNNING           = 4'd7,
    HALTED            = 4'd8
  } state_e;

  // Status codes, upper byte is the fault group
  typedef enum logic [`HWM_CODE_W-1:0] {
    EMPTY                = 25'h000,
    OK                   = 25'h001,
    PS_SHUTDOWN          = 25'h002,  // sys_en dropped
    SPI_START_TIMEOUT    = 25'h100,
    SPI_INIT_TIMEOUT     = 25'h101,
    INTEG_THRESH_AVG_OOB = 25'h200,  // Pre-start config group
    INTEG_WINDOW_OOB     = 25'h201,
    INTEG_EN_OOB         = 25'h202,
    SYS_EN_OOB           = 25'h203,
    LOCK_VIOL            = 25'h204,
    SHUTDOWN_SENSE       = 25'h300,  // Shutdown group
    EXT_SHUTDOWN         = 25'h301,
    OVER_THRESH          = 25'h400,  // Integrator threshold core
    THRESH_UNDERFLOW     = 25'h401,
    THRESH_OVERFLOW      = 25'h402,
    BAD_TRIG_CMD         = 25'h500,  // Trigger buffer and commands
    TRIG_BUF_OVERFLOW    = 25'h501
  } status_code_e;

  typedef logic [`HWM_NUM_BOARDS-1:0] board_mask_t;  // One bit per board

  // Config checks, only looked at on sys_en
  typedef struct packed {
    logic integ_thresh_avg_oob;
    logic integ_window_oob;
    logic integ_en_oob;
    logic sys_en_oob;
  } prestart_flags_t;

  // Faults watched while running, field order is the priority order
  typedef struct packed {
    logic        lock_viol;
    board_mask_t shutdown_sense;
    logic        ext_shutdown;
    board_mask_t over_thresh;
    board_mask_t thresh_underflow;
    board_mask_t thresh_overflow;
    logic        bad_trig_cmd;
    logic        trig_buf_overflow;
  } run_flags_t;

  typedef struct packed {
    logic                     valid;  // Any flag of the group set
    status_code_e             code;
    logic [`HWM_BOARD_W-1:0]  board;  // Lowest offending board
  } fault_report_t;

  // Power and enable controls, n_ prefix is active low
  typedef struct packed {
    logic unlock_cfg;
    logic spi_clk_power_n;
    logic spi_en;
    logic shutdown_sense_en;
    logic trig_en;
    logic n_shutdown_force;
    logic n_shutdown_rst;
  } power_ctrl_t;

  typedef struct packed {
    logic [`HWM_BOARD_W-1:0] board;  // Bits 31:29
    status_code_e            code;   // Bits 28:4
    state_e                  state;  // Bits 3:0
  } status_word_t;

endpackage

`default_nettype wire

// ==== src/fault_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hw_manager_macros.svh"

module fault_arbiter (
  input  wire hw_manager_pkg::prestart_flags_t pre,
  input  wire hw_manager_pkg::run_flags_t      run,
  output hw_manager_pkg::fault_report_t        prestart_fault,
  output hw_manager_pkg::fault_report_t        run_fault
);

  // Lowest set bit wins, empty mask gives 0
  function automatic logic [`HWM_BOARD_W-1:0] lowest_board(
    input hw_manager_pkg::board_mask_t mask
  );
    logic [`HWM_BOARD_W-1:0] idx;
    idx = '0;
    for (int i = `HWM_NUM_BOARDS - 1; i >= 0; i--) begin
      if (mask[i]) idx = i[`HWM_BOARD_W-1:0];  // Later hit is lower index
    end
    return idx;
  endfunction

  // Pre-start checks, all single bit so board stays 0
  always_comb begin
    prestart_fault.valid = |pre;
    prestart_fault.code  = hw_manager_pkg::EMPTY;
    prestart_fault.board = '0;
    if (pre.integ_thresh_avg_oob)
      prestart_fault.code = hw_manager_pkg::INTEG_THRESH_AVG_OOB;
    else if (pre.integ_window_oob)
      prestart_fault.code = hw_manager_pkg::INTEG_WINDOW_OOB;
    else if (pre.integ_en_oob)
      prestart_fault.code = hw_manager_pkg::INTEG_EN_OOB;
    else if (pre.sys_en_oob)
      prestart_fault.code = hw_manager_pkg::SYS_EN_OOB;
  end

  // Run faults, first match in fixed order
  always_comb begin
    run_fault.valid = |run;
    run_fault.code  = hw_manager_pkg::EMPTY;
    run_fault.board = '0;
    if (run.lock_viol) begin
      run_fault.code = hw_manager_pkg::LOCK_VIOL;
    end else if (|run.shutdown_sense) begin
      run_fault.code  = hw_manager_pkg::SHUTDOWN_SENSE;
      run_fault.board = lowest_board(run.shutdown_sense);
    end else if (run.ext_shutdown) begin
      run_fault.code = hw_manager_pkg::EXT_SHUTDOWN;
    end else if (|run.over_thresh) begin
      run_fault.code  = hw_manager_pkg::OVER_THRESH;
      run_fault.board = lowest_board(run.over_thresh);
    end else if (|run.thresh_underflow) begin
      run_fault.code  = hw_manager_pkg::THRESH_UNDERFLOW;  // Threshold FIFO empty read
      run_fault.board = lowest_board(run.thresh_underflow);
    end else if (|run.thresh_overflow) begin
      run_fault.code  = hw_manager_pkg::THRESH_OVERFLOW;
      run_fault.board = lowest_board(run.thresh_overflow);
    end else if (run.bad_trig_cmd) begin
      run_fault.code = hw_manager_pkg::BAD_TRIG_CMD;
    end else if (run.trig_buf_overflow) begin
      run_fault.code = hw_manager_pkg::TRIG_BUF_OVERFLOW;
    end
  end

endmodule

`default_nettype wire

// ==== src/power_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hw_manager_macros.svh"

module power_sequencer #(
  parameter int SHUTDOWN_FORCE_DELAY = `HWM_SHUTDOWN_FORCE_DELAY,
  parameter int SHUTDOWN_RESET_PULSE = `HWM_SHUTDOWN_RESET_PULSE,
  parameter int SHUTDOWN_RESET_DELAY = `HWM_SHUTDOWN_RESET_DELAY,
  parameter int SPI_INIT_WAIT        = `HWM_SPI_INIT_WAIT,
  parameter int SPI_START_WAIT       = `HWM_SPI_START_WAIT
) (
  input  wire                                clk,
  input  wire                                aresetn,
  input  wire                                sys_en,
  input  wire                                spi_off,
  input  wire hw_manager_pkg::fault_report_t prestart_fault,
  input  wire hw_manager_pkg::fault_report_t run_fault,
  output hw_manager_pkg::power_ctrl_t        ctrl,
  output hw_manager_pkg::status_word_t       status,
  output logic                               ps_interrupt
);

  // Timer limits at full timer width
  localparam logic [`HWM_TIMER_W-1:0] FORCE_LIM = SHUTDOWN_FORCE_DELAY;
  localparam logic [`HWM_TIMER_W-1:0] PULSE_LIM = SHUTDOWN_RESET_PULSE;
  localparam logic [`HWM_TIMER_W-1:0] RST_LIM   = SHUTDOWN_RESET_DELAY;
  localparam logic [`HWM_TIMER_W-1:0] INIT_LIM  = SPI_INIT_WAIT;
  localparam logic [`HWM_TIMER_W-1:0] START_LIM = SPI_START_WAIT;
  localparam logic [`HWM_TIMER_W-1:0] INIT_MIN  = `HWM_SPI_INIT_MIN;

  hw_manager_pkg::state_e       state;
  hw_manager_pkg::status_code_e status_code;   // Latched at halt
  logic [`HWM_BOARD_W-1:0]      board_num;
  logic [`HWM_TIMER_W-1:0]      timer;         // Shared, cleared on each transition

  assign status = '{board: board_num, code: status_code, state: state};

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state        <= hw_manager_pkg::IDLE;
      timer        <= '0;
      status_code  <= hw_manager_pkg::OK;
      board_num    <= '0;
      ps_interrupt <= 1'b0;
      ctrl         <= '{unlock_cfg: 1'b1, spi_clk_power_n: 1'b1, n_shutdown_rst: 1'b1,
                        default: 1'b0};
    end else begin
      ps_interrupt <= 1'b0;          // One cycle pulse
      timer        <= timer + 1'b1;
      case (state)
        hw_manager_pkg::IDLE: begin
          if (sys_en) begin
            timer <= '0;
            if (prestart_fault.valid) begin   // Bad config, cfg stays unlocked
              state        <= hw_manager_pkg::HALTED;
              status_code  <= prestart_fault.code;
              board_num    <= prestart_fault.board;
              ps_interrupt <= 1'b1;
            end else begin
              state                <= hw_manager_pkg::CONFIRM_SPI_INIT;
              ctrl.unlock_cfg      <= 1'b0;   // Lock config
              ctrl.spi_clk_power_n <= 1'b0;   // Clock on to read spi_off
            end
          end
        end
        hw_manager_pkg::CONFIRM_SPI_INIT: begin
          if (timer >= INIT_MIN && spi_off) begin
            state                 <= hw_manager_pkg::RELEASE_SD_F;
            timer                 <= '0;
            ctrl.spi_clk_power_n  <= 1'b1;
            ctrl.n_shutdown_force <= 1'b1;    // Release force
          end else if (timer >= INIT_LIM) begin
            state                <= hw_manager_pkg::HALTED;
            timer                <= '0;
            ctrl.spi_clk_power_n <= 1'b1;
            status_code          <= hw_manager_pkg::SPI_INIT_TIMEOUT;
            ps_interrupt         <= 1'b1;
          end
        end
        hw_manager_pkg::RELEASE_SD_F: begin
          if (timer >= FORCE_LIM) begin
            state               <= hw_manager_pkg::PULSE_SD_RST;
            timer               <= '0;
            ctrl.n_shutdown_rst <= 1'b0;      // Start reset pulse
          end
        end
        hw_manager_pkg::PULSE_SD_RST: begin
          if (timer >= PULSE_LIM) begin
            state               <= hw_manager_pkg::SD_RST_DELAY;
            timer               <= '0;
            ctrl.n_shutdown_rst <= 1'b1;
          end
        end
        hw_manager_pkg::SD_RST_DELAY: begin
          if (timer >= RST_LIM) begin
            state                  <= hw_manager_pkg::CONFIRM_SPI_START;
            timer                  <= '0;
            ctrl.shutdown_sense_en <= 1'b1;
            ctrl.spi_clk_power_n   <= 1'b0;
            ctrl.spi_en            <= 1'b1;
          end
        end
        hw_manager_pkg::CONFIRM_SPI_START: begin
          if (!spi_off) begin                 // SPI side is up
            state        <= hw_manager_pkg::RUNNING;
            timer        <= '0;
            ctrl.trig_en <= 1'b1;
            ps_interrupt <= 1'b1;
          end else if (timer >= START_LIM) begin
            state                  <= hw_manager_pkg::HALTED;
            timer                  <= '0;
            ctrl.n_shutdown_force  <= 1'b0;
            ctrl.shutdown_sense_en <= 1'b0;
            ctrl.spi_clk_power_n   <= 1'b1;
            ctrl.spi_en            <= 1'b0;
            status_code            <= hw_manager_pkg::SPI_START_TIMEOUT;
            ps_interrupt           <= 1'b1;
          end
        end
        hw_manager_pkg::RUNNING: begin
          if (!sys_en || run_fault.valid) begin
            state                  <= hw_manager_pkg::HALTED;
            timer                  <= '0;
            ctrl.n_shutdown_force  <= 1'b0;   // Everything off at once
            ctrl.shutdown_sense_en <= 1'b0;
            ctrl.spi_clk_power_n   <= 1'b1;
            ctrl.spi_en            <= 1'b0;
            ctrl.trig_en           <= 1'b0;
            ps_interrupt           <= 1'b1;
            if (!sys_en) begin                // Software shutdown outranks faults
              status_code <= hw_manager_pkg::PS_SHUTDOWN;
              board_num   <= '0;
            end else begin
              status_code <= run_fault.code;
              board_num   <= run_fault.board;
            end
          end
        end
        hw_manager_pkg::HALTED: begin
          // Hold status until software drops sys_en
          if (!sys_en) begin
            state           <= hw_manager_pkg::IDLE;
            timer           <= '0;
            status_code     <= hw_manager_pkg::OK;
            board_num       <= '0;
            ctrl.unlock_cfg <= 1'b1;
          end
        end
        default: begin
          state <= hw_manager_pkg::IDLE;
          timer <= '0;
        end
      endcase
    end
  end

  // Interrupt is a single cycle pulse
  a_irq_pulse: assert property (@(posedge clk) disable iff (!aresetn)
    ps_interrupt |=> !ps_interrupt)
    else $error("ps_interrupt high for two cycles");

  // Triggers only while running
  a_trig_running: assert property (@(posedge clk) disable iff (!aresetn)
    ctrl.trig_en |-> state == hw_manager_pkg::RUNNING)
    else $error("trig_en outside RUNNING");

  a_rst_pulse: assert property (@(posedge clk) disable iff (!aresetn)
    !ctrl.n_shutdown_rst |-> state == hw_manager_pkg::PULSE_SD_RST)
    else $error("n_shutdown_rst low outside PULSE_SD_RST");

endmodule

`default_nettype wire

// ==== src/hw_manager_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hw_manager_macros.svh"

module hw_manager_top #(
  parameter int SHUTDOWN_FORCE_DELAY = `HWM_SHUTDOWN_FORCE_DELAY,
  parameter int SHUTDOWN_RESET_PULSE = `HWM_SHUTDOWN_RESET_PULSE,
  parameter int SHUTDOWN_RESET_DELAY = `HWM_SHUTDOWN_RESET_DELAY,
  parameter int SPI_INIT_WAIT        = `HWM_SPI_INIT_WAIT,
  parameter int SPI_START_WAIT       = `HWM_SPI_START_WAIT
) (
  input  wire                              clk,
  input  wire                              aresetn,
  input  wire                              sys_en,
  input  wire                              spi_off,
  input  wire                              ext_shutdown,
  input  wire                              integ_thresh_avg_oob,
  input  wire                              integ_window_oob,
  input  wire                              integ_en_oob,
  input  wire                              sys_en_oob,
  input  wire                              lock_viol,
  input  wire                              bad_trig_cmd,
  input  wire                              trig_buf_overflow,
  input  wire hw_manager_pkg::board_mask_t shutdown_sense,
  input  wire hw_manager_pkg::board_mask_t over_thresh,
  input  wire hw_manager_pkg::board_mask_t thresh_underflow,
  input  wire hw_manager_pkg::board_mask_t thresh_overflow,
  output logic                             unlock_cfg,
  output logic                             spi_clk_power_n,
  output logic                             spi_en,
  output logic                             shutdown_sense_en,
  output logic                             trig_en,
  output logic                             n_shutdown_force,
  output logic                             n_shutdown_rst,
  output hw_manager_pkg::status_word_t     status_word,
  output logic                             ps_interrupt
);

  hw_manager_pkg::prestart_flags_t pre_flags;
  hw_manager_pkg::run_flags_t      run_flags;
  hw_manager_pkg::fault_report_t   prestart_fault;
  hw_manager_pkg::fault_report_t   run_fault;
  hw_manager_pkg::power_ctrl_t     ctrl;

  // Bundle loose flags for the arbiter
  assign pre_flags = '{integ_thresh_avg_oob: integ_thresh_avg_oob,
                       integ_window_oob:     integ_window_oob,
                       integ_en_oob:         integ_en_oob,
                       sys_en_oob:           sys_en_oob};
  assign run_flags = '{lock_viol:         lock_viol,
                       shutdown_sense:    shutdown_sense,
                       ext_shutdown:      ext_shutdown,
                       over_thresh:       over_thresh,
                       thresh_underflow:  thresh_underflow,
                       thresh_overflow:   thresh_overflow,
                       bad_trig_cmd:      bad_trig_cmd,
                       trig_buf_overflow: trig_buf_overflow};

  fault_arbiter u_arbiter (
    .pre            (pre_flags),
    .run            (run_flags),
    .prestart_fault (prestart_fault),
    .run_fault      (run_fault)
  );

  power_sequencer #(
    .SHUTDOWN_FORCE_DELAY (SHUTDOWN_FORCE_DELAY),
    .SHUTDOWN_RESET_PULSE (SHUTDOWN_RESET_PULSE),
    .SHUTDOWN_RESET_DELAY (SHUTDOWN_RESET_DELAY),
    .SPI_INIT_WAIT        (SPI_INIT_WAIT),
    .SPI_START_WAIT       (SPI_START_WAIT)
  ) u_sequencer (
    .clk            (clk),
    .aresetn        (aresetn),
    .sys_en         (sys_en),
    .spi_off        (spi_off),
    .prestart_fault (prestart_fault),
    .run_fault      (run_fault),
    .ctrl           (ctrl),
    .status         (status_word),
    .ps_interrupt   (ps_interrupt)
  );

  // Control bundle out to pins
  assign unlock_cfg        = ctrl.unlock_cfg;
  assign spi_clk_power_n   = ctrl.spi_clk_power_n;
  assign spi_en            = ctrl.spi_en;
  assign shutdown_sense_en = ctrl.shutdown_sense_en;
  assign trig_en           = ctrl.trig_en;
  assign n_shutdown_force  = ctrl.n_shutdown_force;
  assign n_shutdown_rst    = ctrl.n_shutdown_rst;

endmodule

`default_nettype wire

// ==== testbench/tb_hw_manager_checks.svh ====
`ifndef TB_HW_MANAGER_CHECKS_SVH
`define TB_HW_MANAGER_CHECKS_SVH

int err_count     = 0;
int test_count    = 0;
int test_err_base = 0;  // Errors before the current test

// Scan upward, keep the first hit
function automatic logic [`HWM_BOARD_W-1:0] first_board(input hw_manager_pkg::board_mask_t m);
  logic [`HWM_BOARD_W-1:0] b;
  logic found;
  b     = '0;
  found = 1'b0;
  for (int i = 0; i < `HWM_NUM_BOARDS; i++) begin
    if (m[i] && !found) begin
      b     = i[`HWM_BOARD_W-1:0];
      found = 1'b1;
    end
  end
  return b;
endfunction

// Expected halt report for a set of run flags
function automatic hw_manager_pkg::fault_report_t expected_fault(
  input hw_manager_pkg::run_flags_t f,
  input logic                       en
);
  hw_manager_pkg::fault_report_t r;
  r.valid = 1'b1;
  r.code  = hw_manager_pkg::EMPTY;
  r.board = '0;
  if (!en)
    r.code = hw_manager_pkg::PS_SHUTDOWN;  // Dropped sys_en beats any fault
  else if (f.lock_viol)
    r.code = hw_manager_pkg::LOCK_VIOL;
  else if (f.shutdown_sense != '0) begin
    r.code  = hw_manager_pkg::SHUTDOWN_SENSE;
    r.board = first_board(f.shutdown_sense);
  end else if (f.ext_shutdown)
    r.code = hw_manager_pkg::EXT_SHUTDOWN;
  else if (f.over_thresh != '0) begin
    r.code  = hw_manager_pkg::OVER_THRESH;
    r.board = first_board(f.over_thresh);
  end else if (f.thresh_underflow != '0) begin
    r.code  = hw_manager_pkg::THRESH_UNDERFLOW;
    r.board = first_board(f.thresh_underflow);
  end else if (f.thresh_overflow != '0) begin
    r.code  = hw_manager_pkg::THRESH_OVERFLOW;
    r.board = first_board(f.thresh_overflow);
  end else if (f.bad_trig_cmd)
    r.code = hw_manager_pkg::BAD_TRIG_CMD;
  else if (f.trig_buf_overflow)
    r.code = hw_manager_pkg::TRIG_BUF_OVERFLOW;
  else
    r.valid = 1'b0;  // Nothing to report
  return r;
endfunction

task automatic check_code(input string name, input hw_manager_pkg::status_code_e exp);
  if (status_word.code !== exp) begin
    $display("ERR %s: code expected %s (%h), got %h", name, exp.name(), exp, status_word.code);
    err_count++;
  end
endtask

task automatic check_board(input string name, input logic [`HWM_BOARD_W-1:0] exp);
  if (status_word.board !== exp) begin
    $display("ERR %s: board expected %0d, got %0d", name, exp, status_word.board);
    err_count++;
  end
endtask

task automatic check_state(input string name, input hw_manager_pkg::state_e exp);
  if (status_word.state !== exp) begin
    $display("ERR %s: state expected %s, got %h", name, exp.name(), status_word.state);
    err_count++;
  end
endtask

// Whole control bundle at once
task automatic check_ctrl(input string name, input hw_manager_pkg::power_ctrl_t exp);
  if (ctrl_seen !== exp) begin
    $display("ERR %s: controls expected %b, got %b", name, exp, ctrl_seen);
    err_count++;
  end
endtask

task automatic check_count(input string name, input int exp, input int act);
  if (act != exp) begin
    $display("ERR %s: interrupt count expected %0d, got %0d", name, exp, act);
    err_count++;
  end
endtask

// Poll on falling edges, give up after limit cycles
task automatic wait_state(input string name, input hw_manager_pkg::state_e target,
                          input int limit);
  int n;
  @(negedge clk);
  n = 1;
  while (status_word.state !== target && n < limit) begin
    @(negedge clk);
    n++;
  end
  if (status_word.state !== target) begin
    $display("%s: timed out waiting %0d cycles for state %s", name, limit, target.name());
    err_count++;
  end
endtask

task automatic finish_test(input string name);
  test_count++;
  if (err_count == test_err_base)
    $display("PASS %s", name);
  else
    $display("FAIL %s: %0d errors", name, err_count - test_err_base);
  test_err_base = err_count;
endtask

`endif

// ==== testbench/tb_hw_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hw_manager_macros.svh"

module tb_hw_manager;

  localparam int SPI_NORMAL    = 0;  // Follows spi_en
  localparam int SPI_HOLD_LOW  = 1;
  localparam int SPI_HOLD_HIGH = 2;

  // Expected control bundles
  localparam hw_manager_pkg::power_ctrl_t CTRL_IDLE =
    '{unlock_cfg: 1'b1, spi_clk_power_n: 1'b1, n_shutdown_rst: 1'b1, default: 1'b0};
  localparam hw_manager_pkg::power_ctrl_t CTRL_RUN =
    '{unlock_cfg: 1'b0, spi_clk_power_n: 1'b0, default: 1'b1};
  localparam hw_manager_pkg::power_ctrl_t CTRL_HALT =
    '{spi_clk_power_n: 1'b1, n_shutdown_rst: 1'b1, default: 1'b0};  // Cfg still locked

  logic clk, aresetn, sys_en, spi_off;
  logic integ_thresh_avg_oob, integ_window_oob, integ_en_oob, sys_en_oob;
  logic lock_viol, ext_shutdown, bad_trig_cmd, trig_buf_overflow;
  hw_manager_pkg::board_mask_t shutdown_sense, over_thresh, thresh_underflow, thresh_overflow;
  logic unlock_cfg, spi_clk_power_n, spi_en, shutdown_sense_en;
  logic trig_en, n_shutdown_force, n_shutdown_rst, ps_interrupt;
  hw_manager_pkg::status_word_t status_word;
  hw_manager_pkg::power_ctrl_t  ctrl_seen;

  int   spi_mode      = SPI_NORMAL;
  int   spi_delay_cnt = 0;
  int   irq_count     = 0;     // Interrupt pulses seen so far
  logic rst_seen_low  = 1'b0;  // Shutdown reset pulse observed
  hw_manager_pkg::status_code_e pre_codes [4] = '{hw_manager_pkg::INTEG_THRESH_AVG_OOB,
    hw_manager_pkg::INTEG_WINDOW_OOB, hw_manager_pkg::INTEG_EN_OOB, hw_manager_pkg::SYS_EN_OOB};

  assign ctrl_seen = {unlock_cfg, spi_clk_power_n, spi_en, shutdown_sense_en,
                      trig_en, n_shutdown_force, n_shutdown_rst};

  `include "tb_hw_manager_checks.svh"

  hw_manager_top #(
    .SHUTDOWN_FORCE_DELAY (20),
    .SHUTDOWN_RESET_PULSE (5),
    .SHUTDOWN_RESET_DELAY (20),
    .SPI_INIT_WAIT        (60),
    .SPI_START_WAIT       (80)
  ) DUT (.*);

  always #2 clk = ~clk;  // 4 ns period

  // SPI subsystem model, turns off with spi_en and on 3 cycles after it
  always @(negedge clk) begin
    case (spi_mode)
      SPI_HOLD_LOW:  spi_off = 1'b0;
      SPI_HOLD_HIGH: spi_off = 1'b1;
      default: begin
        if (!spi_en) begin
          spi_off       = 1'b1;
          spi_delay_cnt = 0;
        end else if (spi_delay_cnt < 3)
          spi_delay_cnt++;
        else
          spi_off = 1'b0;
      end
    endcase
  end

  always @(negedge clk) begin
    if (ps_interrupt) irq_count++;
    if (!n_shutdown_rst) rst_seen_low = 1'b1;
  end

  task automatic drive_run_flags(input hw_manager_pkg::run_flags_t f);
    lock_viol         = f.lock_viol;
    shutdown_sense    = f.shutdown_sense;
    ext_shutdown      = f.ext_shutdown;
    over_thresh       = f.over_thresh;
    thresh_underflow  = f.thresh_underflow;
    thresh_overflow   = f.thresh_overflow;
    bad_trig_cmd      = f.bad_trig_cmd;
    trig_buf_overflow = f.trig_buf_overflow;
  endtask

  task automatic set_prestart(input logic [3:0] flags);
    {integ_thresh_avg_oob, integ_window_oob, integ_en_oob, sys_en_oob} = flags;
  endtask

  // Sparse random flags, upper fields cleared so every priority level shows up
  function automatic hw_manager_pkg::run_flags_t random_flags();
    hw_manager_pkg::run_flags_t f;
    logic [63:0] rnd;
    int lvl;
    rnd = {$urandom, $urandom} & {$urandom, $urandom};
    f   = rnd[35:0];
    lvl = $urandom_range(7, 0);
    if (lvl > 0) f.lock_viol = 1'b0;
    if (lvl > 1) f.shutdown_sense = '0;
    if (lvl > 2) f.ext_shutdown = 1'b0;
    if (lvl > 3) f.over_thresh = '0;
    if (lvl > 4) f.thresh_underflow = '0;
    if (lvl > 5) f.thresh_overflow = '0;
    if (lvl > 6) f.bad_trig_cmd = 1'b0;
    if (f == '0) f.trig_buf_overflow = 1'b1;  // Never all clear
    return f;
  endfunction

  task automatic power_up(input string name);
    int irq_before;
    irq_before   = irq_count;
    rst_seen_low = 1'b0;
    @(negedge clk);
    sys_en = 1'b1;
    wait_state(name, hw_manager_pkg::RUNNING, 200);
    @(negedge clk);                   // Let the monitor count the pulse
    check_ctrl(name, CTRL_RUN);
    check_count(name, irq_before + 1, irq_count);
    if (!rst_seen_low) begin
      $display("%s: n_shutdown_rst never went low during power-up", name);
      err_count++;
    end
  endtask

  // Drop sys_en and all flags, expect a clean IDLE
  task automatic leave_halted(input string name);
    @(negedge clk);
    sys_en = 1'b0;
    set_prestart(4'b0);
    drive_run_flags('0);
    wait_state(name, hw_manager_pkg::IDLE, 4);
    check_code(name, hw_manager_pkg::OK);
    check_board(name, '0);
    check_ctrl(name, CTRL_IDLE);
  endtask

  initial begin
    hw_manager_pkg::run_flags_t    flags;
    hw_manager_pkg::fault_report_t exp;
    int irq_before;
    void'($urandom(32'h45ea));
    clk     = 1'b0;
    aresetn = 1'b0;
    sys_en  = 1'b0;
    spi_off = 1'b1;
    set_prestart(4'b0);
    drive_run_flags('0);
    repeat (2) @(negedge clk);
    aresetn = 1'b1;

    @(negedge clk);
    check_state("reset", hw_manager_pkg::IDLE);
    check_code("reset", hw_manager_pkg::OK);
    check_board("reset", '0);
    check_ctrl("reset", CTRL_IDLE);
    check_count("reset", 0, irq_count + int'(ps_interrupt));
    finish_test("reset");

    for (int i = 0; i < 4; i++) begin
      irq_before = irq_count;
      @(negedge clk);
      sys_en = 1'b1;
      set_prestart(4'b1000 >> i);     // One config flag at a time
      wait_state("prestart", hw_manager_pkg::HALTED, 4);
      @(negedge clk);
      check_code("prestart", pre_codes[i]);
      check_board("prestart", '0);
      check_ctrl("prestart", CTRL_IDLE);
      check_count("prestart", irq_before + 1, irq_count);
      leave_halted("prestart");
    end
    finish_test("prestart");

    power_up("power_up");
    leave_halted("power_up");
    finish_test("power_up");

    spi_mode = SPI_HOLD_LOW;          // SPI never reports off
    @(negedge clk);
    sys_en = 1'b1;
    wait_state("spi_timeouts", hw_manager_pkg::HALTED, 100);
    check_code("spi_timeouts", hw_manager_pkg::SPI_INIT_TIMEOUT);
    check_ctrl("spi_timeouts", CTRL_HALT);
    leave_halted("spi_timeouts");
    spi_mode = SPI_HOLD_HIGH;         // SPI never comes up
    @(negedge clk);
    sys_en = 1'b1;
    wait_state("spi_timeouts", hw_manager_pkg::HALTED, 200);
    check_code("spi_timeouts", hw_manager_pkg::SPI_START_TIMEOUT);
    check_ctrl("spi_timeouts", CTRL_HALT);
    leave_halted("spi_timeouts");
    spi_mode = SPI_NORMAL;
    finish_test("spi_timeouts");

    for (int n = 0; n < 20; n++) begin
      power_up("random_faults");
      flags = random_flags();
      exp   = expected_fault(flags, 1'b1);
      @(negedge clk);
      drive_run_flags(flags);
      wait_state("random_faults", hw_manager_pkg::HALTED, 1);  // Halt on the next edge
      check_code("random_faults", exp.code);
      check_board("random_faults", exp.board);
      check_ctrl("random_faults", CTRL_HALT);
      leave_halted("random_faults");
    end
    finish_test("random_faults");

    power_up("ps_shutdown");
    flags      = random_flags();
    exp        = expected_fault(flags, 1'b0);
    irq_before = irq_count;
    @(negedge clk);
    sys_en = 1'b0;                    // Same cycle as the fault
    drive_run_flags(flags);
    wait_state("ps_shutdown", hw_manager_pkg::HALTED, 1);
    check_code("ps_shutdown", exp.code);
    check_board("ps_shutdown", exp.board);
    check_ctrl("ps_shutdown", CTRL_HALT);
    leave_halted("ps_shutdown");
    check_count("ps_shutdown", irq_before + 1, irq_count);
    finish_test("ps_shutdown");

    $display("%0d tests run, %0d errors", test_count, err_count);
    if (err_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
+incdir+testbench
src/hw_manager_pkg.sv
src/fault_arbiter.sv
src/power_sequencer.sv
src/hw_manager_top.sv
testbench/tb_hw_manager.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hw_manager testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tb_hw_manager \
  -o sim_hw_manager > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_hw_manager > sim.log 2>&1
sim_status=$?
cat sim.log
grep -q "Done: errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
[ "$sim_status" -eq 0 ] || { echo "Simulator exited with status $sim_status"; exit 1; }
echo "Simulation passed"
exit 0
